/* common/dataPath_macros.svh */
// datapath sizing constants, fixed register value and ALU operation codes
`ifndef DATAPATH_MACROS_SVH
`define DATAPATH_MACROS_SVH

// width of every bus in the datapath
`define DATA_WIDTH 32

// the register file holds R0 plus seven general registers
`define REG_COUNT 8
`define REG_SEL_WIDTH 3

// width of the operation code that drives the ALU
`define ALU_SEL_WIDTH 4

// register whose contents are always routed to the display
`define DISPLAY_REG 3

// constant held by R0, which no micro-operation can overwrite
`define REG_FIXED_INIT 0

// ALU operation codes, any code not listed here gives a zero result
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_NOTA  4'd5
`define ALU_PASSA 4'd6
`define ALU_PASSB 4'd7
`define ALU_SHLA  4'd8
`define ALU_SHRA  4'd9

`endif

/* common/dataPathPkg.sv */
// shared bus, selection and control word types of the register-transfer datapath
`include "dataPath_macros.svh"

package dataPathPkg;

	// --------------------------------------------------------------------------
	// plain vector types
	// --------------------------------------------------------------------------

	// one word as it travels on bus A, bus B or bus C
	typedef logic [`DATA_WIDTH-1:0] dataWord_t;

	// index of one of the eight registers
	typedef logic [`REG_SEL_WIDTH-1:0] regSel_t;

	// operation code handed to the ALU
	typedef logic [`ALU_SEL_WIDTH-1:0] aluSel_t;

	// --------------------------------------------------------------------------
	// grouped signals
	// --------------------------------------------------------------------------

	// one micro-operation, issued once per clock cycle
	// a write selection of zero means the cycle writes nothing back
	typedef struct packed {
		regSel_t writeSel;
		regSel_t busASel;
		regSel_t busBSel;
		aluSel_t aluOp;
	} microOp_t;

	// both read buses, as they leave the register file towards the ALU
	typedef struct packed {
		dataWord_t busA;
		dataWord_t busB;
	} operandPair_t;

	// status of the last ALU result
	// all four bits are active high inside the design
	typedef struct packed {
		logic overflow;
		logic carry;
		logic negative;
		logic zero;
	} aluFlags_t;

endpackage

/* regFile/regFile.sv */
// register file with fixed R0, seven writable registers, one-hot write decode and two read ports
`timescale 1ns/1ns
`include "dataPath_macros.svh"

module regFile (
	input logic clock50,
	input logic reset,
	input dataPathPkg::regSel_t writeSel,
	input dataPathPkg::regSel_t busASel,
	input dataPathPkg::regSel_t busBSel,
	input dataPathPkg::dataWord_t busC,
	output dataPathPkg::operandPair_t operands,
	output dataPathPkg::dataWord_t displayData
);
	import dataPathPkg::*;

	// value that R0 presents on every read port
	localparam dataWord_t FixedValue = dataWord_t'(`REG_FIXED_INIT);

	// --------------------------------------------------------------------------
	// storage
	// --------------------------------------------------------------------------

	// general registers R1 to R7
	// R0 has no storage at all, it is a constant on the read side
	dataWord_t regBank [1:`REG_COUNT-1];

	// one write enable per general register, at most one of them is high
	logic [`REG_COUNT-1:1] writeEn;

	// all eight registers as the read multiplexers see them
	dataWord_t regView [`REG_COUNT];

	// --------------------------------------------------------------------------
	// write decoder
	// --------------------------------------------------------------------------

	// one-hot decode of the write selection
	// selection zero would address R0, so it simply leaves every enable low
	always_comb begin
		writeEn = '0;
		if (writeSel != '0) begin
			writeEn[writeSel] = 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// general registers
	// --------------------------------------------------------------------------

	// each register loads bus C on the rising edge when its enable is set
	// while reset is high every register is cleared and writes are ignored
	always_ff @(posedge clock50) begin
		for (int i = 1; i < `REG_COUNT; i++) begin
			if (reset) begin
				regBank[i] <= '0;
			end else if (writeEn[i]) begin
				regBank[i] <= busC;
			end
		end
	end

	// --------------------------------------------------------------------------
	// read side
	// --------------------------------------------------------------------------

	// place the fixed R0 next to the general registers
	// so both read ports can index one array
	always_comb begin
		regView[0] = FixedValue;
		for (int i = 1; i < `REG_COUNT; i++) begin
			regView[i] = regBank[i];
		end
	end

	// two independent read multiplexers
	// both may select the same register in the same cycle
	// reads are combinational, a register written on an edge shows its new
	// value on the buses right after that edge
	assign operands = '{
		busA: regView[busASel],
		busB: regView[busBSel]
	};

	// the display register is tapped straight from the array
	assign displayData = regView[`DISPLAY_REG];

endmodule

/* alu/aluUnit.sv */
// combinational ALU with ten operations and overflow, carry, negative and zero flags
`timescale 1ns/1ns
`include "dataPath_macros.svh"

module aluUnit (
	input dataPathPkg::operandPair_t operands,
	input dataPathPkg::aluSel_t aluOp,
	output dataPathPkg::dataWord_t aluResult,
	output dataPathPkg::aluFlags_t aluFlags
);
	import dataPathPkg::*;

	// index of the sign bit of a word
	localparam int SignBit = `DATA_WIDTH - 1;

	// the two operands, unpacked from the read buses
	dataWord_t busA;
	dataWord_t busB;

	// adder and subtractor outputs, one bit wider to keep the carry out
	logic [`DATA_WIDTH:0] addWide;
	logic [`DATA_WIDTH:0] subWide;

	// signed overflow of each arithmetic path
	logic addOverflow;
	logic subOverflow;

	// selected result and the flags that depend on the operation
	dataWord_t result;
	logic carry;
	logic overflow;

	assign busA = operands.busA;
	assign busB = operands.busB;

	// --------------------------------------------------------------------------
	// arithmetic paths
	// --------------------------------------------------------------------------

	// A plus B with the carry out in the top bit
	assign addWide = {1'b0, busA} + {1'b0, busB};

	// A minus B is formed as A plus the inverse of B plus one
	// so the top bit is the carry out of that sum, high when no borrow occurs
	assign subWide = {1'b0, busA} + {1'b0, ~busB} + {{`DATA_WIDTH{1'b0}}, 1'b1};

	// adding two numbers of equal sign overflows when the sum changes sign
	assign addOverflow = (busA[SignBit] == busB[SignBit])
		&& (addWide[SignBit] != busA[SignBit]);

	// subtracting numbers of opposite sign overflows when the difference
	// takes the sign of B instead of the sign of A
	assign subOverflow = (busA[SignBit] != busB[SignBit])
		&& (subWide[SignBit] != busA[SignBit]);

	// --------------------------------------------------------------------------
	// operation select
	// --------------------------------------------------------------------------

	// carry and overflow only mean something for ADD and SUB
	// every other operation leaves them at zero
	always_comb begin
		result = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (aluOp)
			`ALU_ADD: begin
				result = addWide[`DATA_WIDTH-1:0];
				carry = addWide[`DATA_WIDTH];
				overflow = addOverflow;
			end
			`ALU_SUB: begin
				result = subWide[`DATA_WIDTH-1:0];
				carry = subWide[`DATA_WIDTH];
				overflow = subOverflow;
			end
			`ALU_AND: begin
				result = busA & busB;
			end
			`ALU_OR: begin
				result = busA | busB;
			end
			`ALU_XOR: begin
				result = busA ^ busB;
			end
			`ALU_NOTA: begin
				result = ~busA;
			end
			`ALU_PASSA: begin
				result = busA;
			end
			`ALU_PASSB: begin
				result = busB;
			end
			// shifts move A by one position and fill with zero
			`ALU_SHLA: begin
				result = {busA[`DATA_WIDTH-2:0], 1'b0};
			end
			`ALU_SHRA: begin
				result = {1'b0, busA[`DATA_WIDTH-1:1]};
			end
			// unused codes give a zero result, which also raises the zero flag
			default: begin
				result = '0;
			end
		endcase
	end

	// --------------------------------------------------------------------------
	// outputs
	// --------------------------------------------------------------------------

	assign aluResult = result;

	// negative and zero look only at the selected result
	assign aluFlags = '{
		overflow: overflow,
		carry: carry,
		negative: result[SignBit],
		zero: (result == '0)
	};

endmodule

/* hdl/dataPathTop.sv */
// datapath top level joining the register file and the ALU with write-back over bus C
`timescale 1ns/1ns

module dataPathTop (
	input logic clock50,
	input logic reset,
	input dataPathPkg::microOp_t microOp,
	output dataPathPkg::dataWord_t displayData,
	output dataPathPkg::aluFlags_t flagsN
);
	import dataPathPkg::*;

	// fields of the current micro-operation
	regSel_t writeSel;
	regSel_t busASel;
	regSel_t busBSel;
	aluSel_t aluOp;

	// read buses from the register file into the ALU
	operandPair_t operands;

	// ALU result and the write-back bus that carries it home
	dataWord_t aluResult;
	dataWord_t busC;

	// flags as the ALU produces them, active high
	aluFlags_t aluFlags;

	// --------------------------------------------------------------------------
	// control word split
	// --------------------------------------------------------------------------

	assign writeSel = microOp.writeSel;
	assign busASel = microOp.busASel;
	assign busBSel = microOp.busBSel;
	assign aluOp = microOp.aluOp;

	// --------------------------------------------------------------------------
	// register file, operand side and write-back target
	// --------------------------------------------------------------------------

	regFile regFileInst (
		.clock50(clock50),
		.reset(reset),
		.writeSel(writeSel),
		.busASel(busASel),
		.busBSel(busBSel),
		.busC(busC),
		.operands(operands),
		.displayData(displayData)
	);

	// --------------------------------------------------------------------------
	// ALU
	// --------------------------------------------------------------------------

	aluUnit aluUnitInst (
		.operands(operands),
		.aluOp(aluOp),
		.aluResult(aluResult),
		.aluFlags(aluFlags)
	);

	// the whole path from selection to result is combinational
	// so the result lands in the selected register on the next rising edge
	assign busC = aluResult;

	// flags leave the datapath active low
	assign flagsN = ~aluFlags;

endmodule

/* verification/dataPath_props.sv */
// register-file invariant checks, bound into the register file of the datapath
`timescale 1ns/1ns
`include "dataPath_macros.svh"

module dataPath_props (
	input logic clock50,
	input logic reset,
	input dataPathPkg::regSel_t writeSel,
	input dataPathPkg::regSel_t busASel,
	input dataPathPkg::regSel_t busBSel,
	input dataPathPkg::operandPair_t operands,
	input dataPathPkg::dataWord_t regView [`REG_COUNT]
);
	import dataPathPkg::*;

	// constant that R0 must present on the read ports
	localparam dataWord_t FixedValue = dataWord_t'(`REG_FIXED_INIT);

	// running count of failed assertions, looked up at the end of a run
	int failCount = 0;

	// register contents as they were just before the previous rising edge
	dataWord_t prevView [`REG_COUNT];

	// one bit per register that changed across the previous rising edge
	logic [`REG_COUNT-1:0] changedMask;

	always_ff @(posedge clock50) begin
		for (int i = 0; i < `REG_COUNT; i++) begin
			prevView[i] <= regView[i];
		end
	end

	always_comb begin
		for (int i = 0; i < `REG_COUNT; i++) begin
			changedMask[i] = (regView[i] !== prevView[i]);
		end
	end

	// --------------------------------------------------------------------------
	// fixed register and write decode
	// --------------------------------------------------------------------------

	// whichever read port selects R0 carries the fixed value
	fixedR0: assert property (@(posedge clock50)
		((busASel != '0) || (operands.busA == FixedValue))
		&& ((busBSel != '0) || (operands.busB == FixedValue)))
		else begin
			failCount++;
			$error("R0 read back a value other than its fixed value");
		end

	// the one-hot write decoder lets at most one register load per edge
	singleWrite: assert property (@(posedge clock50) disable iff (reset)
		$countones(changedMask) <= 1)
		else begin
			failCount++;
			$error("more than one register changed on one edge");
		end

	for (genvar i = 1; i < `REG_COUNT; i++) begin : perRegister
		// while reset is high the register is held at zero
		clearedInReset: assert property (@(posedge clock50) reset |=> regView[i] == '0)
			else begin
				failCount++;
				$error("register %0d not held at zero during reset", i);
			end

		// a register that is not selected, or any register when writeSel is zero,
		// keeps its value over the next edge
		heldUnlessSelected: assert property (@(posedge clock50) disable iff (reset)
			(writeSel != regSel_t'(i)) |=> regView[i] == $past(regView[i]))
			else begin
				failCount++;
				$error("register %0d changed without being selected", i);
			end
	end

endmodule

bind regFile dataPath_props regFileChecks (
	.clock50(clock50),
	.reset(reset),
	.writeSel(writeSel),
	.busASel(busASel),
	.busBSel(busBSel),
	.operands(operands),
	.regView(regView)
);

/* verification/dataPathTb.sv */
// testbench for the datapath with reference model, directed and LFSR stimulus and watchdog
`timescale 1ns/1ns
`include "dataPath_macros.svh"

module dataPathTb;
	import dataPathPkg::*;

	localparam int ClockPeriod = 40;
	localparam int DriveDelay = 2;
	localparam int ResetCycles = 8;
	localparam int DirectedCycles = 40;
	localparam int RandomCycles = 400;
	localparam int MarginCycles = 50;
	localparam int TimeoutNs =
		(ResetCycles + DirectedCycles + RandomCycles + MarginCycles) * ClockPeriod;

	// signed range of one data word, for the overflow rule
	localparam longint MaxSigned = (64'sd1 <<< (`DATA_WIDTH - 1)) - 1;
	localparam longint MinSigned = -(64'sd1 <<< (`DATA_WIDTH - 1));

	logic clock50;
	logic reset;
	microOp_t microOp;
	dataWord_t displayData;
	aluFlags_t flagsN;

	// register contents as the testbench expects them
	dataWord_t modelRegs [`REG_COUNT];

	// Galois LFSR state for the random section
	logic [15:0] lfsrState = 16'd15439;

	dataPathTop UUT (
		.clock50(clock50),
		.reset(reset),
		.microOp(microOp),
		.displayData(displayData),
		.flagsN(flagsN)
	);

	always #(ClockPeriod / 2) clock50 = ~clock50;

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------

	// prints the reason, then the fail message, and stops the run
	task automatic stopOnError(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// one step of a 16-bit Galois LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] stepLfsr(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 16'hB400;
		end
		return next;
	endfunction

	// takes count bits from the LFSR, stepping it once per bit
	function automatic logic [31:0] takeRandomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = stepLfsr(lfsrState);
		end
		return bits;
	endfunction

	// expected ALU result and active-high flags for one operation
	function automatic void computeExpected(input dataWord_t a, input dataWord_t b,
		input aluSel_t op, output dataWord_t result, output aluFlags_t flags);
		longint wideSigned;
		result = '0;
		flags = '0;
		case (op)
			`ALU_ADD: begin
				result = a + b;
				// the sum wraps below A exactly when the addition carries out
				flags.carry = (result < a);
				wideSigned = longint'($signed(a)) + longint'($signed(b));
				flags.overflow = (wideSigned > MaxSigned) || (wideSigned < MinSigned);
			end
			`ALU_SUB: begin
				result = a - b;
				// carry out of A plus not B plus one is set exactly when no borrow occurs
				flags.carry = (a >= b);
				wideSigned = longint'($signed(a)) - longint'($signed(b));
				flags.overflow = (wideSigned > MaxSigned) || (wideSigned < MinSigned);
			end
			`ALU_AND: result = a & b;
			`ALU_OR: result = a | b;
			`ALU_XOR: result = a ^ b;
			`ALU_NOTA: result = ~a;
			`ALU_PASSA: result = a;
			`ALU_PASSB: result = b;
			`ALU_SHLA: result = a << 1;
			`ALU_SHRA: result = a >> 1;
			default: result = '0;
		endcase
		flags.negative = result[`DATA_WIDTH-1];
		flags.zero = (result == '0);
	endfunction

	// applies one micro-operation a short delay after the rising edge
	task automatic driveOp(input regSel_t writeSel, input regSel_t busASel,
		input regSel_t busBSel, input aluSel_t aluOp);
		@(posedge clock50);
		#DriveDelay;
		microOp = '{writeSel: writeSel, busASel: busASel, busBSel: busBSel, aluOp: aluOp};
	endtask

	// --------------------------------------------------------------------------
	// comparator
	// --------------------------------------------------------------------------

	// samples just before each rising edge, checks the flags, then follows the write
	initial begin : compareLoop
		microOp_t sampledOp;
		logic sampledReset;
		dataWord_t expResult;
		aluFlags_t expFlags;
		for (int i = 0; i < `REG_COUNT; i++) begin
			modelRegs[i] = dataWord_t'(`REG_FIXED_INIT);
		end
		forever begin
			@(negedge clock50);
			#(ClockPeriod / 2 - 1);
			sampledOp = microOp;
			sampledReset = reset;
			computeExpected(modelRegs[sampledOp.busASel], modelRegs[sampledOp.busBSel],
				sampledOp.aluOp, expResult, expFlags);
			if (!sampledReset) begin
				assert (flagsN === ~expFlags)
					else stopOnError($sformatf("ERR %0t ns: flagsN is %b, expected %b for op %0d",
						$time, flagsN, ~expFlags, sampledOp.aluOp));
			end
			@(posedge clock50);
			if (sampledReset) begin
				for (int i = 1; i < `REG_COUNT; i++) begin
					modelRegs[i] = '0;
				end
			end else if (sampledOp.writeSel != '0) begin
				modelRegs[sampledOp.writeSel] = expResult;
			end
			#1;
			assert (displayData === modelRegs[`DISPLAY_REG])
				else stopOnError($sformatf("ERR %0t ns: displayData is %h, expected %h",
					$time, displayData, modelRegs[`DISPLAY_REG]));
		end
	end

	// --------------------------------------------------------------------------
	// stimulus
	// --------------------------------------------------------------------------

	initial begin : stimulus
		regSel_t randWrite;
		regSel_t randA;
		regSel_t randB;
		aluSel_t randOp;
		int checkFailures;
		clock50 = 1'b0;
		reset = 1'b1;
		microOp = '{writeSel: '0, busASel: '0, busBSel: '0, aluOp: `ALU_ADD};
		repeat (ResetCycles) @(posedge clock50);
		#DriveDelay;
		reset = 1'b0;
		#1;
		// after reset only the zero flag is asserted, so only its bit is low
		assert (displayData === '0 && flagsN === 4'b1110)
			else stopOnError($sformatf("ERR %0t ns: after reset display %h flagsN %b",
				$time, displayData, flagsN));

		// writeSel zero stores nothing, and R0 reads back its constant
		driveOp(0, 0, 0, `ALU_NOTA);
		driveOp(3, 0, 0, `ALU_PASSA);
		driveOp(0, 0, 0, `ALU_ADD);
		#1;
		assert (displayData === dataWord_t'(`REG_FIXED_INIT))
			else stopOnError($sformatf("ERR %0t ns: R0 read back as %h", $time, displayData));

		// build working values without an increment operation
		driveOp(1, 0, 0, `ALU_NOTA);
		driveOp(3, 1, 0, `ALU_PASSA);
		driveOp(2, 1, 0, `ALU_SHLA);
		driveOp(3, 1, 2, `ALU_ADD);
		driveOp(4, 1, 0, `ALU_SHRA);
		driveOp(5, 1, 2, `ALU_XOR);
		driveOp(6, 5, 5, `ALU_ADD);
		driveOp(7, 4, 5, `ALU_ADD);
		driveOp(3, 7, 0, `ALU_PASSA);
		driveOp(0, 0, 0, `ALU_ADD);
		#1;
		assert (displayData === {1'b1, {(`DATA_WIDTH - 1){1'b0}}})
			else stopOnError($sformatf("ERR %0t ns: built value is %h", $time, displayData));

		// every operation code on all ones and two, then one unused code
		for (int code = 0; code < 10; code++) begin
			driveOp(3, 1, 6, aluSel_t'(code));
		end
		driveOp(3, 1, 6, aluSel_t'(12));

		// carry, borrow and signed overflow corners of ADD and SUB
		driveOp(3, 4, 5, `ALU_ADD);
		driveOp(3, 1, 5, `ALU_ADD);
		driveOp(3, 5, 6, `ALU_SUB);
		driveOp(3, 7, 5, `ALU_SUB);
		driveOp(3, 4, 1, `ALU_SUB);
		driveOp(3, 5, 5, `ALU_SUB);

		repeat (RandomCycles) begin
			randWrite = regSel_t'(takeRandomBits(`REG_SEL_WIDTH));
			randA = regSel_t'(takeRandomBits(`REG_SEL_WIDTH));
			randB = regSel_t'(takeRandomBits(`REG_SEL_WIDTH));
			randOp = aluSel_t'(takeRandomBits(`ALU_SEL_WIDTH));
			driveOp(randWrite, randA, randB, randOp);
		end

		// one idle cycle so the last write is compared as well
		driveOp(0, 0, 0, `ALU_ADD);
		@(posedge clock50);
		#5;
		checkFailures = UUT.regFileInst.regFileChecks.failCount;
		if (checkFailures == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			stopOnError($sformatf("the register-file assertions failed %0d times",
				checkFailures));
		end
	end

	// --------------------------------------------------------------------------
	// watchdog
	// --------------------------------------------------------------------------

	initial begin : watchdog
		#(TimeoutNs);
		stopOnError("the test sequence did not finish within the expected run time");
	end

endmodule

/* vlog.f */
+incdir+common
common/dataPathPkg.sv
regFile/regFile.sv
alu/aluUnit.sv
hdl/dataPathTop.sv
verification/dataPath_props.sv
verification/dataPathTb.sv
